//--- verilog/download_pkg.sv
//==============================
// Host download bus widths, download
// index codes, memory region bases and
// the main-memory word and address types
//==============================

package download_pkg;

	//==============================
	// Host download port
	//==============================
	localparam int IOCTL_ADDR_W = 27;
	localparam int IOCTL_WORD_W = 16;

	// One main-memory word is two host words
	typedef logic [31:0]             ram_word_t;
	typedef logic [IOCTL_ADDR_W-1:0] ram_addr_t;
	typedef logic [8:0]              track_addr_t;

	//==============================
	// Download index codes
	//==============================
	localparam logic [7:0] IDX_BIOS   = 8'd0;
	localparam logic [7:0] IDX_EXE    = 8'd1;
	localparam logic [7:0] IDX_SBI    = 8'd250;
	localparam logic [7:0] IDX_CDINFO = 8'd251;
	localparam logic [7:0] IDX_CODE   = 8'd255;

	// Byte offsets added to the host address
	localparam ram_addr_t BIOS_BASE = 27'd2097152;
	localparam ram_addr_t EXE_BASE  = 27'd4194304;

endpackage

//--- verilog/cheat_pkg.sv
//==============================
// Cheat code type and the
// positions of its four fields
//==============================

package cheat_pkg;

	// Each field is one 32-bit value
	localparam int CODE_FIELD_W = 32;

	// Host words that make up one code
	localparam int CODE_WORDS = 8;

	typedef logic [4*CODE_FIELD_W-1:0] code_t;

	//==============================
	// Field layout, flags on top
	//==============================
	localparam int FLAGS_LSB   = 3 * CODE_FIELD_W;
	localparam int ADDR_LSB    = 2 * CODE_FIELD_W;
	localparam int COMPARE_LSB = CODE_FIELD_W;
	localparam int REPLACE_LSB = 0;

endpackage

//--- verilog/download_decoder.sv
//==============================
// Download decoder: registered kind
// flags, load-EXE and code-clear
// pulses, libcrypt key capture
//==============================

`timescale 1ns/1ns

module download_decoder (
	input  logic                                  clk_1x,
	input  logic                                  rst_n,
	input  logic                                  ioctl_download,
	input  logic [7:0]                            ioctl_index,
	input  logic                                  ioctl_wr,
	input  logic [download_pkg::IOCTL_WORD_W-1:0] ioctl_dout,
	output logic                                  bios_active,
	output logic                                  exe_active,
	output logic                                  cdinfo_active,
	output logic                                  code_active,
	output logic                                  load_exe,
	output logic                                  code_clear,
	output logic [download_pkg::IOCTL_WORD_W-1:0] libcrypt_key
);

	logic sbi_active;
	logic exe_active_d;
	logic code_active_d;

	//==============================
	// Kind flags
	//==============================
	always_ff @(posedge clk_1x) begin
		if (!rst_n) begin
			bios_active   <= 1'b0;
			exe_active    <= 1'b0;
			sbi_active    <= 1'b0;
			cdinfo_active <= 1'b0;
			code_active   <= 1'b0;
		end else begin
			bios_active   <= ioctl_download && (ioctl_index == download_pkg::IDX_BIOS);
			exe_active    <= ioctl_download && (ioctl_index == download_pkg::IDX_EXE);
			sbi_active    <= ioctl_download && (ioctl_index == download_pkg::IDX_SBI);
			cdinfo_active <= ioctl_download && (ioctl_index == download_pkg::IDX_CDINFO);
			code_active   <= ioctl_download && (ioctl_index == download_pkg::IDX_CODE);
		end
	end

	//==============================
	// Edge pulses
	//==============================
	always_ff @(posedge clk_1x) begin
		if (!rst_n) begin
			exe_active_d  <= 1'b0;
			code_active_d <= 1'b0;
			load_exe      <= 1'b0;
			code_clear    <= 1'b0;
		end else begin
			exe_active_d  <= exe_active;
			code_active_d <= code_active;
			// EXE download finished, start the program
			load_exe      <= exe_active_d && !exe_active;
			// New code list, drop the old codes
			code_clear    <= code_active && !code_active_d;
		end
	end

	// Key is the last word of the SBI download
	always_ff @(posedge clk_1x) begin
		if (sbi_active && ioctl_wr) begin
			libcrypt_key <= ioctl_dout;
		end
	end

endmodule

//--- verilog/word_packer.sv
//==============================
// Word packer: collects 16-bit host
// words into one payload by address
//==============================

`timescale 1ns/1ns

module word_packer #(
	parameter type payload_t = download_pkg::ram_word_t
) (
	input  logic                                  clk_1x,
	input  logic                                  rst_n,
	input  logic                                  enable,
	input  logic                                  word_wr,
	input  download_pkg::ram_addr_t               word_addr,
	input  logic [download_pkg::IOCTL_WORD_W-1:0] word,
	output payload_t                              payload,
	output logic                                  payload_valid,
	output download_pkg::ram_addr_t               base_addr
);

	localparam int PAYLOAD_W = $bits(payload_t);
	localparam int WORD_W    = download_pkg::IOCTL_WORD_W;
	localparam int FIELD_W   = 2 * WORD_W;
	localparam int SLOTS     = PAYLOAD_W / WORD_W;
	localparam int FIELDS    = SLOTS / 2;
	localparam int SLOT_W    = $clog2(SLOTS);
	localparam int OFF_W     = $clog2(PAYLOAD_W);

	logic                 accept;
	logic [SLOT_W-1:0]    slot;
	logic [OFF_W-1:0]     offset;
	logic [PAYLOAD_W-1:0] data_q;

	assign accept = enable && word_wr;

	// Host addresses are byte addresses of 16-bit words
	assign slot = word_addr[SLOT_W:1];

	// Fields fill from the top, low half at the lower address
	always_comb begin
		offset = OFF_W'((FIELDS - 1 - int'(slot >> 1)) * FIELD_W + int'(slot[0]) * WORD_W);
	end

	always_ff @(posedge clk_1x) begin
		if (accept) begin
			data_q[offset +: WORD_W] <= word;
			if (slot == '0) begin
				base_addr <= word_addr;
			end
		end
	end

	// Done once the last slot is written
	always_ff @(posedge clk_1x) begin
		if (!rst_n) begin
			payload_valid <= 1'b0;
		end else begin
			payload_valid <= accept && (slot == SLOT_W'(SLOTS - 1));
		end
	end

	assign payload = payload_t'(data_q);

endmodule

//--- verilog/ram_loader.sv
//==============================
// RAM loader: packed host words go to
// main memory or to the track-info port,
// host wait while a write is pending
//==============================

`timescale 1ns/1ns

module ram_loader (
	input  logic                                  clk_1x,
	input  logic                                  rst_n,
	input  logic                                  bios_active,
	input  logic                                  exe_active,
	input  logic                                  cdinfo_active,
	input  logic                                  ioctl_wr,
	input  download_pkg::ram_addr_t               ioctl_addr,
	input  logic [download_pkg::IOCTL_WORD_W-1:0] ioctl_dout,
	output logic                                  mem_req,
	output download_pkg::ram_addr_t               mem_addr,
	output download_pkg::ram_word_t               mem_data,
	input  logic                                  mem_done,
	output logic                                  track_wr,
	output download_pkg::track_addr_t             track_addr,
	output download_pkg::ram_word_t               track_data,
	output logic                                  ioctl_wait
);

	download_pkg::ram_word_t packed_word;
	download_pkg::ram_addr_t packed_addr;
	download_pkg::ram_addr_t region_base;
	logic                    packed_valid;
	logic                    mem_active;
	logic                    mem_start;
	logic                    req_hold;

	assign mem_active = bios_active || exe_active;

	word_packer #(
		.payload_t     (download_pkg::ram_word_t)
	) i_word_packer (
		.clk_1x        (clk_1x),
		.rst_n         (rst_n),
		.enable        (bios_active || exe_active || cdinfo_active),
		.word_wr       (ioctl_wr),
		.word_addr     (ioctl_addr),
		.word          (ioctl_dout),
		.payload       (packed_word),
		.payload_valid (packed_valid),
		.base_addr     (packed_addr)
	);

	//==============================
	// Main memory writes
	//==============================
	always_comb begin
		if (exe_active) begin
			region_base = download_pkg::EXE_BASE;
		end else begin
			region_base = download_pkg::BIOS_BASE;
		end
	end

	assign mem_start = packed_valid && mem_active;

	// Held from the packed word until the done pulse
	always_ff @(posedge clk_1x) begin
		if (!rst_n) begin
			req_hold <= 1'b0;
		end else if (!mem_active) begin
			// Download ended, drop whatever is pending
			req_hold <= 1'b0;
		end else begin
			req_hold <= (req_hold || mem_start) && !mem_done;
		end
	end

	assign mem_req  = mem_start || req_hold;
	assign mem_addr = packed_addr + region_base;
	assign mem_data = packed_word;

	// Host stalls for exactly as long as the request is up
	assign ioctl_wait = mem_req;

	//==============================
	// Track-info writes
	//==============================
	assign track_wr   = packed_valid && cdinfo_active;
	assign track_addr = packed_addr[10:2];
	assign track_data = packed_word;

endmodule

//--- verilog/fast_forward_ctl.sv
//==============================
// Fast-forward control: on while
// held, a short tap latches it on
//==============================

`timescale 1ns/1ns

module fast_forward_ctl #(
	parameter int TAP_LIMIT = 10000000
) (
	input  logic clk_1x,
	input  logic rst_n,
	input  logic ff_request,
	output logic fast_forward
);

	localparam int CNT_W = $clog2(TAP_LIMIT + 1);

	logic             request_d;
	logic             press_start;
	logic             press_end;
	logic [CNT_W-1:0] press_cnt;
	logic             ff_latch;
	logic             tap_latched;

	assign press_start = ff_request && !request_d;
	assign press_end   = !ff_request && request_d;

	always_ff @(posedge clk_1x) begin
		if (!rst_n) begin
			request_d    <= 1'b0;
			press_cnt    <= '0;
			ff_latch     <= 1'b0;
			tap_latched  <= 1'b0;
			fast_forward <= 1'b0;
		end else begin
			request_d <= ff_request;
			// Press length, stops at the tap limit
			if (press_start) begin
				press_cnt <= '0;
				ff_latch  <= 1'b0;
			end else if (ff_request && (press_cnt != CNT_W'(TAP_LIMIT))) begin
				press_cnt <= press_cnt + 1'b1;
			end
			// Short tap toggles the latch on, every other release leaves it off
			if (press_end) begin
				if ((press_cnt < CNT_W'(TAP_LIMIT)) && !tap_latched) begin
					ff_latch    <= 1'b1;
					tap_latched <= 1'b1;
				end else begin
					tap_latched <= 1'b0;
				end
			end
			fast_forward <= ff_request || ff_latch;
		end
	end

endmodule

//--- verilog/psx_loader_top.sv
//==============================
// Loader top: download decoder, RAM
// loader, cheat code packer and
// fast-forward control
//==============================

`timescale 1ns/1ns

module psx_loader_top #(
	parameter int FF_TAP_LIMIT = 10000000
) (
	input  logic                                  clk_1x,
	input  logic                                  rst_n,
	// Host download port
	input  logic                                  ioctl_download,
	input  logic [7:0]                            ioctl_index,
	input  download_pkg::ram_addr_t               ioctl_addr,
	input  logic [download_pkg::IOCTL_WORD_W-1:0] ioctl_dout,
	input  logic                                  ioctl_wr,
	output logic                                  ioctl_wait,
	// Main memory port
	output logic                                  mem_req,
	output download_pkg::ram_addr_t               mem_addr,
	output download_pkg::ram_word_t               mem_data,
	input  logic                                  mem_done,
	// CD track info
	output logic                                  track_wr,
	output download_pkg::track_addr_t             track_addr,
	output download_pkg::ram_word_t               track_data,
	// Core control
	output logic                                  load_exe,
	output logic [download_pkg::IOCTL_WORD_W-1:0] libcrypt_key,
	output logic                                  code_clear,
	output logic                                  code_valid,
	output cheat_pkg::code_t                      code,
	input  logic                                  ff_request,
	output logic                                  fast_forward
);

	logic bios_active;
	logic exe_active;
	logic cdinfo_active;
	logic code_active;

	download_decoder i_decoder (
		.clk_1x         (clk_1x),
		.rst_n          (rst_n),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_dout     (ioctl_dout),
		.bios_active    (bios_active),
		.exe_active     (exe_active),
		.cdinfo_active  (cdinfo_active),
		.code_active    (code_active),
		.load_exe       (load_exe),
		.code_clear     (code_clear),
		.libcrypt_key   (libcrypt_key)
	);

	ram_loader i_ram_loader (
		.clk_1x        (clk_1x),
		.rst_n         (rst_n),
		.bios_active   (bios_active),
		.exe_active    (exe_active),
		.cdinfo_active (cdinfo_active),
		.ioctl_wr      (ioctl_wr),
		.ioctl_addr    (ioctl_addr),
		.ioctl_dout    (ioctl_dout),
		.mem_req       (mem_req),
		.mem_addr      (mem_addr),
		.mem_data      (mem_data),
		.mem_done      (mem_done),
		.track_wr      (track_wr),
		.track_addr    (track_addr),
		.track_data    (track_data),
		.ioctl_wait    (ioctl_wait)
	);

	// One code per eight host words
	word_packer #(
		.payload_t     (cheat_pkg::code_t)
	) i_code_packer (
		.clk_1x        (clk_1x),
		.rst_n         (rst_n),
		.enable        (code_active),
		.word_wr       (ioctl_wr),
		.word_addr     (ioctl_addr),
		.word          (ioctl_dout),
		.payload       (code),
		.payload_valid (code_valid),
		.base_addr     ()
	);

	fast_forward_ctl #(
		.TAP_LIMIT    (FF_TAP_LIMIT)
	) i_ff_ctl (
		.clk_1x       (clk_1x),
		.rst_n        (rst_n),
		.ff_request   (ff_request),
		.fast_forward (fast_forward)
	);

endmodule

//--- test/tb_psx_loader_assert.sv
//==============================
// Concurrent checks on the loader
// top: memory handshake, host stall,
// track and code strobes
//==============================

`timescale 1ns/1ns

module tb_psx_loader_assert (
	input logic clk_1x,
	input logic rst_n,
	input logic mem_req,
	input logic mem_done,
	input logic ioctl_wr,
	input logic track_wr,
	input logic code_clear,
	input logic code_valid
);

	// Number of failed assertions so far
	int unsigned fail_count = 0;

	// Request stays up until the memory answers
	a_req_held: assert property (@(posedge clk_1x) disable iff (!rst_n)
		mem_req && !mem_done |=> mem_req)
		else begin
			fail_count++;
			$error("mem_req dropped before mem_done");
		end

	a_one_target: assert property (@(posedge clk_1x) disable iff (!rst_n)
		!(mem_req && track_wr))
		else begin
			fail_count++;
			$error("mem_req and track_wr high together");
		end

	a_code_strobes: assert property (@(posedge clk_1x) disable iff (!rst_n)
		!(code_clear && code_valid))
		else begin
			fail_count++;
			$error("code_clear and code_valid high together");
		end

	// Host must be stalled during a memory write
	a_host_stalled: assert property (@(posedge clk_1x) disable iff (!rst_n)
		mem_req |-> !ioctl_wr)
		else begin
			fail_count++;
			$error("host wrote while mem_req was high");
		end

endmodule

bind psx_loader_top tb_psx_loader_assert i_assert (
	.clk_1x     (clk_1x),
	.rst_n      (rst_n),
	.mem_req    (mem_req),
	.mem_done   (mem_done),
	.ioctl_wr   (ioctl_wr),
	.track_wr   (track_wr),
	.code_clear (code_clear),
	.code_valid (code_valid)
);

//--- test/tb_psx_loader.sv
//==============================
// Loader testbench: host and memory
// models, LFSR stimulus, reference
// queues, checks and watchdog
//==============================

`timescale 1ns/1ns

module tb_psx_loader;

	localparam int TAP_LIMIT = 64;
	localparam int N_BIOS    = 16;
	localparam int N_EXE     = 16;
	localparam int N_CDINFO  = 12;
	localparam int N_SBI     = 6;
	localparam int N_CODES   = 3;
	localparam int N_PRESSES = 12;
	// Twelve cycles per host word plus at most 161 cycles per press and its gap
	localparam int WATCHDOG_CYCLES =
		(N_BIOS + N_EXE + N_CDINFO + N_SBI + N_CODES * cheat_pkg::CODE_WORDS) * 12
		+ N_PRESSES * 161 + 400;

	logic                                  clk_1x;
	logic                                  rst_n;
	logic                                  ioctl_download;
	logic [7:0]                            ioctl_index;
	download_pkg::ram_addr_t               ioctl_addr;
	logic [download_pkg::IOCTL_WORD_W-1:0] ioctl_dout;
	logic                                  ioctl_wr;
	logic                                  ioctl_wait;
	logic                                  mem_req;
	download_pkg::ram_addr_t               mem_addr;
	download_pkg::ram_word_t               mem_data;
	logic                                  mem_done;
	logic                                  track_wr;
	download_pkg::track_addr_t             track_addr;
	download_pkg::ram_word_t               track_data;
	logic                                  load_exe;
	logic [download_pkg::IOCTL_WORD_W-1:0] libcrypt_key;
	logic                                  code_clear;
	logic                                  code_valid;
	cheat_pkg::code_t                      code;
	logic                                  ff_request;
	logic                                  fast_forward;

	logic [31:0]      lfsr;
	logic [58:0]      mem_q[$];
	logic [40:0]      track_q[$];
	cheat_pkg::code_t code_q[$];
	logic [15:0]      last_word;
	int               clear_count;
	int               errors;
	logic             cdinfo_phase;
	// Fast-forward reference state
	logic             model_req;
	logic             model_latch;
	logic             model_tapped;
	int               press_cycles;

	psx_loader_top #(
		.FF_TAP_LIMIT (TAP_LIMIT)
	) i_dut (.*);

	initial begin : clock_gen
		clk_1x = 1'b0;
		forever #4 clk_1x = ~clk_1x;
	end

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < n; i++) begin
			lfsr  = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			value = {value[30:0], lfsr[0]};
		end
		return value;
	endfunction

	task automatic finish_failed();
		$display("Something failed");
		$fatal(1, "Stopping the simulation");
	endtask

	task automatic check_value(input logic [127:0] actual, input logic [127:0] expected,
			input string what);
		if (actual !== expected) begin
			errors++;
			$display("Error at %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
			finish_failed();
		end
	endtask

	//==============================
	// Host model
	//==============================
	task automatic write_word(input download_pkg::ram_addr_t addr, input logic [15:0] data);
		ioctl_addr = addr;
		ioctl_dout = data;
		ioctl_wr   = 1'b1;
		@(posedge clk_1x);
		#1;
		ioctl_wr = 1'b0;
		// Look at the wait two cycles after the upper half
		if (addr[1]) begin
			@(posedge clk_1x);
			#1;
			while (ioctl_wait) begin
				@(posedge clk_1x);
				#1;
			end
		end
	endtask

	task automatic run_download(input logic [7:0] idx, input int n_words,
			input download_pkg::ram_addr_t start);
		download_pkg::ram_addr_t addr;
		download_pkg::ram_addr_t base;
		logic [15:0]             data;
		logic [31:0]             pair;
		cheat_pkg::code_t        code_acc;
		ioctl_index    = idx;
		ioctl_download = 1'b1;
		repeat (2) @(posedge clk_1x);
		#1;
		for (int i = 0; i < n_words; i++) begin
			addr = start + download_pkg::ram_addr_t'(2 * i);
			data = 16'(rand_bits(16));
			if (addr[1]) begin
				base = addr - 27'd2;
				pair = {data, last_word};
				// Field number from the address, flags at the lowest
				case (addr[3:2])
					2'd0: code_acc[cheat_pkg::FLAGS_LSB +: cheat_pkg::CODE_FIELD_W] = pair;
					2'd1: code_acc[cheat_pkg::ADDR_LSB +: cheat_pkg::CODE_FIELD_W] = pair;
					2'd2: code_acc[cheat_pkg::COMPARE_LSB +: cheat_pkg::CODE_FIELD_W] = pair;
					default: code_acc[cheat_pkg::REPLACE_LSB +: cheat_pkg::CODE_FIELD_W] = pair;
				endcase
				case (idx)
					download_pkg::IDX_BIOS:
						mem_q.push_back({base + download_pkg::BIOS_BASE, pair});
					download_pkg::IDX_EXE:
						mem_q.push_back({base + download_pkg::EXE_BASE, pair});
					download_pkg::IDX_CDINFO:
						track_q.push_back({base[10:2], pair});
					default: ;
				endcase
				if ((idx == download_pkg::IDX_CODE) && (addr[3:1] == 3'd7)) begin
					code_q.push_back(code_acc);
				end
			end
			last_word = data;
			write_word(addr, data);
		end
		ioctl_download = 1'b0;
	endtask

	task automatic drain_and_check(input string name);
		repeat (4) @(posedge clk_1x);
		#1;
		check_value(mem_q.size(), 0, {name, " memory writes left"});
		check_value(track_q.size(), 0, {name, " track writes left"});
		check_value(code_q.size(), 0, {name, " codes left"});
		check_value(ioctl_wait, 1'b0, {name, " ioctl_wait"});
	endtask

	//==============================
	// Memory model and monitors
	//==============================
	initial begin : memory_model
		int delay;
		forever begin
			@(negedge clk_1x);
			if (rst_n && mem_req) begin
				if (mem_q.size() == 0) begin
					$display("Unexpected memory request to address %h", mem_addr);
					finish_failed();
				end else begin
					check_value({mem_addr, mem_data}, mem_q.pop_front(), "memory write");
					delay = 1 + rand_bits(2);
					repeat (delay) @(posedge clk_1x);
					#1;
					mem_done = 1'b1;
					@(posedge clk_1x);
					#1;
					mem_done = 1'b0;
				end
			end
		end
	end

	always @(negedge clk_1x) begin
		if (rst_n) begin
			if (i_dut.i_assert.fail_count != 0) begin
				$display("A concurrent assertion on the loader top failed");
				finish_failed();
			end
			if (track_wr && (track_q.size() == 0)) begin
				$display("Unexpected track-info write to %h", track_addr);
				finish_failed();
			end else if (track_wr) begin
				check_value({track_addr, track_data}, track_q.pop_front(), "track write");
			end
			if (code_valid && (code_q.size() == 0)) begin
				$display("Unexpected cheat code %h", code);
				finish_failed();
			end else if (code_valid) begin
				check_value(code, code_q.pop_front(), "cheat code");
			end
			if (code_clear) begin
				clear_count++;
			end
			if (cdinfo_phase) begin
				check_value(ioctl_wait, 1'b0, "ioctl_wait during CD info");
			end
		end
	end

	//==============================
	// Fast-forward stimulus and model
	//==============================
	task automatic ff_step(input logic req);
		logic expected;
		ff_request = req;
		@(posedge clk_1x);
		// Output is the request or the latch one cycle late
		expected = req || model_latch;
		if (req && !model_req) begin
			model_latch  = 1'b0;
			press_cycles = 1;
		end else if (req) begin
			press_cycles++;
		end else if (model_req) begin
			model_tapped = (press_cycles < TAP_LIMIT) && !model_tapped;
			model_latch  = model_tapped;
		end
		model_req = req;
		#1;
		check_value(fast_forward, expected, "fast_forward");
	endtask

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge clk_1x);
		$display("Simulation timed out after %0d cycles", WATCHDOG_CYCLES);
		finish_failed();
	end

	initial begin : stimulus
		int exe_pulses;
		int len;
		rst_n          = 1'b0;
		ioctl_download = 1'b0;
		ioctl_index    = '0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		ioctl_wr       = 1'b0;
		mem_done       = 1'b0;
		ff_request     = 1'b0;
		lfsr           = 32'h0b01cebc;
		last_word      = '0;
		clear_count    = 0;
		errors         = 0;
		cdinfo_phase   = 1'b0;
		model_req      = 1'b0;
		model_latch    = 1'b0;
		model_tapped   = 1'b0;
		press_cycles   = 0;
		repeat (4) @(posedge clk_1x);
		#1;
		rst_n = 1'b1;

		run_download(download_pkg::IDX_BIOS, N_BIOS, {16'(rand_bits(16)), 2'b00});
		drain_and_check("BIOS");

		run_download(download_pkg::IDX_EXE, N_EXE, {16'(rand_bits(16)), 2'b00});
		exe_pulses = 0;
		for (int i = 0; i < 6; i++) begin
			@(negedge clk_1x);
			if (load_exe) begin
				exe_pulses++;
				check_value(i, 2, "load_exe delay");
			end
		end
		check_value(exe_pulses, 1, "load_exe pulse count");
		drain_and_check("EXE");

		cdinfo_phase = 1'b1;
		run_download(download_pkg::IDX_CDINFO, N_CDINFO, {9'(rand_bits(9)), 2'b00});
		drain_and_check("CD info");
		cdinfo_phase = 1'b0;

		run_download(download_pkg::IDX_SBI, N_SBI, '0);
		drain_and_check("SBI");
		check_value(libcrypt_key, last_word, "libcrypt key");

		clear_count = 0;
		run_download(download_pkg::IDX_CODE, N_CODES * cheat_pkg::CODE_WORDS,
			{8'(rand_bits(8)), 4'b0000});
		drain_and_check("code");
		check_value(clear_count, 1, "code_clear pulse count");

		// Mostly taps with some long holds
		for (int p = 0; p < N_PRESSES; p++) begin
			if (rand_bits(2) != 0) begin
				len = 2 + rand_bits(5);
			end else begin
				len = 80 + rand_bits(6);
			end
			repeat (len) ff_step(1'b1);
			repeat (3 + rand_bits(4)) ff_step(1'b0);
		end

		if (errors == 0) begin
			$display("Everything OK");
			$finish;
		end else begin
			finish_failed();
		end
	end

endmodule

//--- files.f
verilog/download_pkg.sv
verilog/cheat_pkg.sv
verilog/download_decoder.sv
verilog/word_packer.sv
verilog/ram_loader.sv
verilog/fast_forward_ctl.sv
verilog/psx_loader_top.sv
test/tb_psx_loader_assert.sv
test/tb_psx_loader.sv
